//--- Bender.yml
package:
  name: block_sync

sources:
  - block_sync_pkg.sv
  - sh_window_extract.sv
  - block_lock_fsm.sv
  - block_output_stage.sv
  - block_sync_rx.sv
  - target: test
    files:
      - block_sync_checker.sv
      - block_sync_assert.sv
      - block_sync_tb.sv

//--- block_lock_fsm.sv
`timescale 1ns/1ps

module block_lock_fsm
(
	input  logic                                    i_clock,
	input  logic                                    i_arst_n,
	input  logic                                    i_accept,
	input  logic                                    i_signal_ok,
	input  logic                                    i_sh_ok,
	input  block_sync_pkg::sync_cfg_t               i_cfg,
	output block_sync_pkg::lock_state_e             o_state,
	output logic [block_sync_pkg::INDEX_BITS-1:0]   o_search_index,
	output logic [block_sync_pkg::INDEX_BITS-1:0]   o_block_index
);

	import block_sync_pkg::*;

	lock_state_e                state;
	lock_state_e                nxt_state;
	logic [INDEX_BITS-1:0]      search_index;
	logic [INDEX_BITS-1:0]      nxt_search_index;
	logic [INDEX_BITS-1:0]      block_index;
	logic [INDEX_BITS-1:0]      nxt_block_index;
	logic [WINDOW_BITS-1:0]     win_cnt;     // good headers when unlocked, words when locked
	logic [WINDOW_BITS-1:0]     nxt_win_cnt;
	logic [INVALID_BITS-1:0]    inv_cnt;
	logic [INVALID_BITS-1:0]    nxt_inv_cnt;

	// one spare bit so the compare never wraps
	logic [WINDOW_BITS:0]       win_inc;
	logic [INVALID_BITS:0]      inv_inc;
	logic                       win_done_unlocked;
	logic                       win_done_locked;
	logic                       inv_full;

	assign win_inc = {1'b0, win_cnt} + 1'b1;
	assign inv_inc = {1'b0, inv_cnt} + {{INVALID_BITS{1'b0}}, ~i_sh_ok};

	assign win_done_unlocked = (win_inc >= {1'b0, i_cfg.unlocked_limit});
	assign win_done_locked   = (win_inc >= {1'b0, i_cfg.locked_limit});
	assign inv_full          = !i_sh_ok && (inv_inc >= {1'b0, i_cfg.invalid_limit});

	always_comb
	begin
		nxt_state        = state;
		nxt_search_index = search_index;
		nxt_block_index  = block_index;
		nxt_win_cnt      = win_cnt;
		nxt_inv_cnt      = inv_cnt;

		case (state)
			ST_UNLOCKED:
			begin
				nxt_inv_cnt = '0;
				if (!i_sh_ok)
				begin
					// slip to the next offset, restart the good run
					nxt_win_cnt = '0;
					if (search_index == INDEX_BITS'(MAX_INDEX))
					begin
						nxt_search_index = '0;
					end
					else
					begin
						nxt_search_index = search_index + 1'b1;
					end
				end
				else if (win_done_unlocked)
				begin
					nxt_state       = ST_LOCKED;
					nxt_block_index = search_index; // freeze the boundary
					nxt_win_cnt     = '0;
				end
				else
				begin
					nxt_win_cnt = win_inc[WINDOW_BITS-1:0];
				end
			end

			ST_LOCKED:
			begin
				if (inv_full)
				begin
					// too many bad headers, search again from offset 0
					nxt_state        = ST_UNLOCKED;
					nxt_search_index = '0;
					nxt_win_cnt      = '0;
					nxt_inv_cnt      = '0;
				end
				else if (win_done_locked)
				begin
					nxt_win_cnt = '0; // window over, start a fresh one
					nxt_inv_cnt = '0;
				end
				else
				begin
					nxt_win_cnt = win_inc[WINDOW_BITS-1:0];
					nxt_inv_cnt = inv_inc[INVALID_BITS-1:0];
				end
			end

			default:
			begin
				nxt_state = ST_UNLOCKED;
			end
		endcase
	end

	always_ff @(posedge i_clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			state        <= ST_UNLOCKED;
			search_index <= '0;
			block_index  <= '0;
			win_cnt      <= '0;
			inv_cnt      <= '0;
		end
		else if (!i_signal_ok)
		begin
			// no signal, hold everything cleared
			state        <= ST_UNLOCKED;
			search_index <= '0;
			block_index  <= '0;
			win_cnt      <= '0;
			inv_cnt      <= '0;
		end
		else if (i_accept)
		begin
			state        <= nxt_state;
			search_index <= nxt_search_index;
			block_index  <= nxt_block_index;
			win_cnt      <= nxt_win_cnt;
			inv_cnt      <= nxt_inv_cnt;
		end
	end

	assign o_state        = state;
	assign o_search_index = search_index;
	assign o_block_index  = block_index;

endmodule

//--- block_output_stage.sv
`timescale 1ns/1ps

module block_output_stage
(
	input  logic                                        i_clock,
	input  logic                                        i_arst_n,
	input  logic                                        i_raw_valid,
	input  logic                                        i_locked,
	input  block_sync_pkg::blk_type_e                   i_header_type,
	input  logic [block_sync_pkg::PAYLOAD_BITS-1:0]     i_payload,
	input  logic                                        i_blk_ready,
	output logic                                        o_raw_ready,
	output logic                                        o_accept,
	output logic                                        o_blk_valid,
	output block_sync_pkg::rx_block_t                   o_blk
);

	import block_sync_pkg::*;

	logic       blk_valid;
	rx_block_t  blk_q;
	rx_block_t  blk_d;
	logic       load;

	// room when empty or when the held block leaves this cycle
	assign o_raw_ready = !blk_valid || i_blk_ready;
	assign o_accept    = i_raw_valid && o_raw_ready;

	// only words judged under lock make a block
	assign load = o_accept && i_locked;

	always_comb
	begin
		blk_d.blk_type = i_header_type;
		blk_d.payload  = i_payload;
	end

	always_ff @(posedge i_clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			blk_valid <= 1'b0;
		end
		else if (load)
		begin
			blk_valid <= 1'b1; // refill, possibly in the same cycle as a drain
		end
		else if (i_blk_ready)
		begin
			blk_valid <= 1'b0;
		end
	end

	// payload register
	always_ff @(posedge i_clock)
	begin
		if (load)
		begin
			blk_q <= blk_d;
		end
	end

	assign o_blk_valid = blk_valid;
	assign o_blk       = blk_q;

endmodule

//--- block_sync.f
block_sync_pkg.sv
sh_window_extract.sv
block_lock_fsm.sv
block_output_stage.sv
block_sync_rx.sv
block_sync_checker.sv
block_sync_assert.sv
block_sync_tb.sv

//--- block_sync_assert.sv
`timescale 1ns/1ps

module block_sync_assert
(
	input  logic                                    i_clock,
	input  logic                                    i_arst_n,
	input  logic                                    i_blk_valid,
	input  logic                                    i_blk_ready,
	input  block_sync_pkg::rx_block_t               i_blk,
	input  logic                                    i_block_lock,
	input  logic [block_sync_pkg::INDEX_BITS-1:0]   i_block_index
);

	int fail_count = 0;

	// a stalled block stays put
	hold_until_ready: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_blk_valid && !i_blk_ready |=> i_blk_valid && $stable(i_blk))
	else
	begin
		$error("output block dropped or changed while stalled");
		fail_count++;
	end

	no_block_unlocked: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		!i_block_lock && !i_blk_valid |=> !i_blk_valid)
	else
	begin
		$error("output valid rose while unlocked");
		fail_count++;
	end

	// boundary frozen for as long as lock holds
	index_frozen: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_block_lock |=> !i_block_lock || $stable(i_block_index))
	else
	begin
		$error("block index moved while locked");
		fail_count++;
	end

endmodule

bind block_sync_rx block_sync_assert u_assert
(
	.i_clock       (i_clock),
	.i_arst_n      (i_arst_n),
	.i_blk_valid   (o_blk_valid),
	.i_blk_ready   (i_blk_ready),
	.i_blk         (o_blk),
	.i_block_lock  (o_block_lock),
	.i_block_index (o_block_index)
);

//--- block_sync_checker.sv
`timescale 1ns/1ps

module block_sync_checker
(
	input  logic                                    i_clock,
	input  logic                                    i_arst_n,
	input  logic                                    i_signal_ok,
	input  block_sync_pkg::sync_cfg_t               i_cfg,
	input  logic                                    i_raw_valid,
	input  logic                                    i_raw_ready,
	input  block_sync_pkg::raw_word_t               i_raw,
	input  logic                                    i_blk_valid,
	input  logic                                    i_blk_ready,
	input  block_sync_pkg::rx_block_t               i_blk,
	input  logic                                    i_block_lock,
	input  logic [block_sync_pkg::INDEX_BITS-1:0]   i_block_index
);

	import block_sync_pkg::*;

	rx_block_t                  tx_q[$];  // filled by the stream generator
	rx_block_t                  exp_q[$]; // blocks the DUT still owes
	int                         err_count = 0;

	raw_word_t                  prev_word;
	logic [2*BLOCK_BITS-1:0]    hist;
	logic [1:0]                 sh;
	logic                       sh_ok;
	logic                       accept;
	lock_state_e                state;
	int                         search_index;
	int                         block_index;
	int                         good_cnt;
	int                         win_cnt;
	int                         inv_cnt;
	int                         word_cnt;
	rx_block_t                  tx;

	// everything is sampled half a cycle before the edge it predicts
	always @(negedge i_clock)
	begin
		accept = i_raw_valid && i_raw_ready;
		if (!i_arst_n)
		begin
			tx_q.delete();
			exp_q.delete();
			prev_word = '0;
			state     = ST_UNLOCKED;
			search_index = 0;
			block_index  = 0;
			good_cnt  = 0;
			win_cnt   = 0;
			inv_cnt   = 0;
			word_cnt  = 0;
		end
		else
		begin
			if (i_block_lock !== (state == ST_LOCKED) || i_block_index !== block_index)
			begin
				$display("mismatch at %0t: lock %0b index %0d, model lock %0b index %0d",
					$time, i_block_lock, i_block_index, state == ST_LOCKED, block_index);
				err_count++;
			end
			// input stalls only while a held block is blocked
			if (i_raw_ready !== (!i_blk_valid || i_blk_ready))
			begin
				$display("mismatch at %0t: raw ready %0b with block valid %0b ready %0b",
					$time, i_raw_ready, i_blk_valid, i_blk_ready);
				err_count++;
			end
			if (i_blk_valid && i_blk_ready)
			begin
				if (exp_q.size() == 0)
				begin
					$display("%0t: DUT sent a block that the model did not expect", $time);
					err_count++;
				end
				else if (i_blk !== exp_q[0])
				begin
					$display("mismatch at %0t: block %0d/%h, expected %0d/%h", $time,
						i_blk.blk_type, i_blk.payload, exp_q[0].blk_type, exp_q[0].payload);
					err_count++;
					void'(exp_q.pop_front());
				end
				else
				begin
					void'(exp_q.pop_front());
				end
			end
			if (accept && word_cnt > 0)
			begin
				// word j closes transmitted block j-1
				if (tx_q.size() == 0)
				begin
					$display("%0t: accepted word has no transmitted block behind it", $time);
					err_count++;
				end
				else
				begin
					tx = tx_q.pop_front();
					if (state == ST_LOCKED)
					begin
						exp_q.push_back(tx);
					end
				end
			end
			if (!i_signal_ok)
			begin
				state = ST_UNLOCKED;
				search_index = 0;
				block_index  = 0;
				good_cnt = 0;
				win_cnt  = 0;
				inv_cnt  = 0;
			end
			else if (accept)
			begin
				hist  = {i_raw, prev_word};
				sh    = hist[search_index +: 2];
				sh_ok = (sh == 2'b01) || (sh == 2'b10);
				if (state == ST_UNLOCKED && !sh_ok)
				begin
					good_cnt = 0;
					search_index = (search_index == MAX_INDEX) ? 0 : search_index + 1;
				end
				else if (state == ST_UNLOCKED)
				begin
					good_cnt++;
					if (good_cnt == i_cfg.unlocked_limit)
					begin
						state = ST_LOCKED;
						block_index = search_index;
						good_cnt = 0;
						win_cnt  = 0;
						inv_cnt  = 0;
					end
				end
				else
				begin
					win_cnt++;
					inv_cnt += sh_ok ? 0 : 1;
					if (inv_cnt == i_cfg.invalid_limit)
					begin
						state = ST_UNLOCKED; // restart search at 0
						search_index = 0;
						good_cnt = 0;
						win_cnt  = 0;
						inv_cnt  = 0;
					end
					else if (win_cnt == i_cfg.locked_limit)
					begin
						win_cnt = 0;
						inv_cnt = 0;
					end
				end
			end
			if (accept)
			begin
				prev_word = i_raw;
				word_cnt++;
			end
		end
	end

endmodule

//--- block_sync_pkg.sv
package block_sync_pkg;

	// block geometry
	localparam int BLOCK_BITS   = 66;
	localparam int PAYLOAD_BITS = 64;

	// offset search, 0 .. MAX_INDEX
	localparam int INDEX_BITS = 7;
	localparam int MAX_INDEX  = 65;

	// window timer and invalid header counter
	localparam int WINDOW_BITS  = 11;
	localparam int INVALID_BITS = 4;

	// one deserializer word, bit 0 received first
	typedef logic [BLOCK_BITS-1:0] raw_word_t;

	typedef enum logic
	{
		ST_UNLOCKED = 1'b0,
		ST_LOCKED   = 1'b1
	} lock_state_e;

	// follows bit 1 of the sync header (01 data, 10 control)
	typedef enum logic
	{
		BT_DATA = 1'b0,
		BT_CTRL = 1'b1
	} blk_type_e;

	// aligned block as it leaves the receiver
	typedef struct packed
	{
		blk_type_e                blk_type;
		logic [PAYLOAD_BITS-1:0]  payload;
	} rx_block_t;

	// run-time lock configuration
	typedef struct packed
	{
		logic [WINDOW_BITS-1:0]  unlocked_limit; // good headers needed to lock
		logic [WINDOW_BITS-1:0]  locked_limit;   // locked window length in words
		logic [INVALID_BITS-1:0] invalid_limit;  // bad headers per window to unlock
	} sync_cfg_t;

endpackage

//--- block_sync_rx.sv
`timescale 1ns/1ps

module block_sync_rx
(
	input  logic                                    i_clock,
	input  logic                                    i_arst_n,
	input  logic                                    i_signal_ok,
	input  block_sync_pkg::sync_cfg_t               i_cfg,
	input  logic                                    i_raw_valid,
	output logic                                    o_raw_ready,
	input  block_sync_pkg::raw_word_t               i_raw,
	output logic                                    o_blk_valid,
	input  logic                                    i_blk_ready,
	output block_sync_pkg::rx_block_t               o_blk,
	output logic                                    o_block_lock,
	output logic [block_sync_pkg::INDEX_BITS-1:0]   o_block_index
);

	import block_sync_pkg::*;

	logic                       accept;
	logic                       sh_ok;
	lock_state_e                state;
	logic [INDEX_BITS-1:0]      search_index;
	logic [INDEX_BITS-1:0]      block_index;
	blk_type_e                  header_type;
	logic [PAYLOAD_BITS-1:0]    payload;
	logic                       locked;

	assign locked = (state == ST_LOCKED);

	block_lock_fsm u_lock_fsm
	(
		.i_clock        (i_clock),
		.i_arst_n       (i_arst_n),
		.i_accept       (accept),
		.i_signal_ok    (i_signal_ok),
		.i_sh_ok        (sh_ok),
		.i_cfg          (i_cfg),
		.o_state        (state),
		.o_search_index (search_index),
		.o_block_index  (block_index)
	);

	sh_window_extract u_extract
	(
		.i_clock        (i_clock),
		.i_arst_n       (i_arst_n),
		.i_accept       (accept),
		.i_raw          (i_raw),
		.i_search_index (search_index),
		.i_block_index  (block_index),
		.o_sh_ok        (sh_ok),
		.o_header_type  (header_type),
		.o_payload      (payload)
	);

	block_output_stage u_out_stage
	(
		.i_clock        (i_clock),
		.i_arst_n       (i_arst_n),
		.i_raw_valid    (i_raw_valid),
		.i_locked       (locked), // state before the accepting edge
		.i_header_type  (header_type),
		.i_payload      (payload),
		.i_blk_ready    (i_blk_ready),
		.o_raw_ready    (o_raw_ready),
		.o_accept       (accept),
		.o_blk_valid    (o_blk_valid),
		.o_blk          (o_blk)
	);

	assign o_block_lock  = locked;
	assign o_block_index = block_index;

endmodule

//--- block_sync_tb.sv
`timescale 1ns/1ps

module block_sync_tb;

	import block_sync_pkg::*;

	localparam int NUM_ROWS   = 10;
	localparam int DROP_WORDS = 4;    // words sent with i_signal_ok low
	localparam int WAIT_LIMIT = 2000; // cycles per wait loop

	typedef struct packed
	{
		logic [6:0]  slip;
		logic [9:0]  n_blocks;
		logic [4:0]  n_corrupt;
		logic [9:0]  corrupt_at;  // first block with a bad header
		logic [9:0]  drop_at;     // word where i_signal_ok drops, 0 for never
		logic [6:0]  bp_pct;      // percent of cycles with i_blk_ready low
		logic        exp_lock;
		logic [1:0]  exp_drops;   // falling edges of o_block_lock
	} scenario_t;

	localparam scenario_t SCEN [NUM_ROWS] = '{
		'{7'd0,  10'd300, 5'd0,  10'd0,   10'd0,   7'd0,  1'b1, 2'd0},
		'{7'd1,  10'd300, 5'd0,  10'd0,   10'd0,   7'd0,  1'b1, 2'd0},
		'{7'd33, 10'd300, 5'd0,  10'd0,   10'd0,   7'd0,  1'b1, 2'd0},
		'{7'd65, 10'd400, 5'd0,  10'd0,   10'd0,   7'd0,  1'b1, 2'd0},
		'{7'd17, 10'd500, 5'd5,  10'd300, 10'd0,   7'd0,  1'b1, 2'd0},
		'{7'd40, 10'd600, 5'd16, 10'd250, 10'd0,   7'd0,  1'b1, 2'd1},
		'{7'd9,  10'd500, 5'd0,  10'd0,   10'd250, 7'd0,  1'b1, 2'd1},
		'{7'd50, 10'd300, 5'd0,  10'd0,   10'd296, 7'd40, 1'b0, 2'd1},
		'{7'd23, 10'd400, 5'd0,  10'd0,   10'd0,   7'd50, 1'b1, 2'd0},
		'{7'd61, 10'd400, 5'd0,  10'd0,   10'd0,   7'd75, 1'b1, 2'd0}
	};

	logic        i_clock;
	logic        i_arst_n;
	logic        i_signal_ok;
	sync_cfg_t   i_cfg;
	logic        i_raw_valid;
	logic        o_raw_ready;
	raw_word_t   i_raw;
	logic        o_blk_valid;
	logic        i_blk_ready;
	rx_block_t   o_blk;
	logic        o_block_lock;
	logic [INDEX_BITS-1:0] o_block_index;

	raw_word_t   words_q[$];
	int          tb_errors;
	int          lock_drops;
	logic        lock_seen;
	bit          timed_out;

	block_sync_rx i_block_sync_rx
	(
		.i_clock(i_clock), .i_arst_n(i_arst_n), .i_signal_ok(i_signal_ok), .i_cfg(i_cfg),
		.i_raw_valid(i_raw_valid), .o_raw_ready(o_raw_ready), .i_raw(i_raw),
		.o_blk_valid(o_blk_valid), .i_blk_ready(i_blk_ready), .o_blk(o_blk),
		.o_block_lock(o_block_lock), .o_block_index(o_block_index)
	);

	block_sync_checker u_checker
	(
		.i_clock(i_clock), .i_arst_n(i_arst_n), .i_signal_ok(i_signal_ok), .i_cfg(i_cfg),
		.i_raw_valid(i_raw_valid), .i_raw_ready(o_raw_ready), .i_raw(i_raw),
		.i_blk_valid(o_blk_valid), .i_blk_ready(i_blk_ready), .i_blk(o_blk),
		.i_block_lock(o_block_lock), .i_block_index(o_block_index)
	);

	initial
	begin
		i_clock = 1'b0;
		forever
		begin
			#50 i_clock = ~i_clock;
		end
	end

	task automatic apply_reset();
		i_arst_n    = 1'b0;
		i_signal_ok = 1'b1;
		i_raw_valid = 1'b0;
		repeat (5) @(posedge i_clock);
		#10;
		i_arst_n = 1'b1;
	endtask

	// random blocks, shifted by the slip, cut into raw words
	task automatic build_stream(input scenario_t sc);
		bit          stream_q[$];
		rx_block_t   tx;
		logic [1:0]  hdr;
		raw_word_t   blk;
		raw_word_t   word;
		words_q.delete();
		for (int i = 0; i < sc.slip; i++)
		begin
			stream_q.push_back($urandom_range(1) != 0);
		end
		for (int n = 0; n < sc.n_blocks; n++)
		begin
			tx.blk_type = ($urandom_range(1) != 0) ? BT_CTRL : BT_DATA;
			tx.payload  = {$urandom, $urandom};
			hdr = (tx.blk_type == BT_CTRL) ? 2'b10 : 2'b01;
			if (n >= sc.corrupt_at && n < sc.corrupt_at + sc.n_corrupt)
			begin
				hdr[0] = ~hdr[0]; // 00 or 11, type bit kept
			end
			blk = {tx.payload, hdr};
			for (int b = 0; b < BLOCK_BITS; b++)
			begin
				stream_q.push_back(blk[b]); // lsb goes first on the line
			end
			u_checker.tx_q.push_back(tx);
		end
		for (int w = 0; w < sc.n_blocks; w++)
		begin
			for (int b = 0; b < BLOCK_BITS; b++)
			begin
				word[b] = stream_q.pop_front();
			end
			words_q.push_back(word);
		end
	endtask

	task automatic send_words(input int row, input scenario_t sc);
		int  waited;
		bit  taken;
		lock_seen  = 1'b0;
		lock_drops = 0;
		for (int w = 0; w < words_q.size() && !timed_out; w++)
		begin
			i_raw_valid = 1'b1;
			i_raw       = words_q[w];
			i_signal_ok = !(sc.drop_at != 0 && w >= sc.drop_at && w < sc.drop_at + DROP_WORDS);
			taken  = 1'b0;
			waited = 0;
			while (!taken && waited < WAIT_LIMIT)
			begin
				i_blk_ready = ($urandom_range(99) >= sc.bp_pct);
				@(negedge i_clock);
				taken = o_raw_ready;
				if (lock_seen && !o_block_lock)
				begin
					lock_drops++;
				end
				lock_seen = o_block_lock;
				@(posedge i_clock);
				#10;
				waited++;
			end
			if (!taken)
			begin
				$display("row %0d: word %0d was not accepted in %0d cycles", row, w, WAIT_LIMIT);
				timed_out = 1'b1;
			end
		end
		i_raw_valid = 1'b0;
	endtask

	// let the output register empty, then judge the row
	task automatic finish_row(input int row, input scenario_t sc);
		int    waited;
		bit    drained;
		logic  [INDEX_BITS-1:0] exp_index;
		waited  = 0;
		drained = 1'b0;
		while (!drained && waited < WAIT_LIMIT)
		begin
			i_blk_ready = ($urandom_range(99) >= sc.bp_pct);
			@(negedge i_clock);
			drained = !o_blk_valid;
			@(posedge i_clock);
			#10;
			waited++;
		end
		if (!drained)
		begin
			$display("row %0d: output block never drained", row);
			timed_out = 1'b1;
		end
		exp_index = sc.exp_lock ? sc.slip : '0;
		@(negedge i_clock);
		if (o_block_lock !== sc.exp_lock || o_block_index !== exp_index)
		begin
			$display("mismatch at %0t: row %0d lock %0b index %0d, expected %0b index %0d",
				$time, row, o_block_lock, o_block_index, sc.exp_lock, exp_index);
			tb_errors++;
		end
		if (lock_drops != sc.exp_drops)
		begin
			$display("mismatch at %0t: row %0d lock fell %0d times, expected %0d",
				$time, row, lock_drops, sc.exp_drops);
			tb_errors++;
		end
		if (u_checker.exp_q.size() != 0)
		begin
			$display("row %0d: %0d blocks were lost", row, u_checker.exp_q.size());
			tb_errors++;
		end
		@(posedge i_clock);
		#10;
	endtask

	initial
	begin
		void'($urandom(32'hf0c4_705c));
		i_arst_n    = 1'b0;
		i_signal_ok = 1'b1;
		i_cfg       = '{unlocked_limit: 11'd32, locked_limit: 11'd64, invalid_limit: 4'd8};
		i_raw_valid = 1'b0;
		i_raw       = '0;
		i_blk_ready = 1'b1;
		tb_errors   = 0;
		timed_out   = 1'b0;
		for (int r = 0; r < NUM_ROWS && !timed_out; r++)
		begin
			apply_reset();
			build_stream(SCEN[r]);
			send_words(r, SCEN[r]);
			if (!timed_out)
			begin
				finish_row(r, SCEN[r]);
			end
		end
		$display("errors: checker %0d, assertions %0d, testbench %0d, timeout %0b",
			u_checker.err_count, i_block_sync_rx.u_assert.fail_count, tb_errors, timed_out);
		if (!timed_out && u_checker.err_count == 0 && tb_errors == 0
			&& i_block_sync_rx.u_assert.fail_count == 0)
		begin
			$display("TEST RESULT: PASS");
		end
		else
		begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- sh_window_extract.sv
`timescale 1ns/1ps

module sh_window_extract
(
	input  logic                                        i_clock,
	input  logic                                        i_arst_n,
	input  logic                                        i_accept,
	input  block_sync_pkg::raw_word_t                   i_raw,
	input  logic [block_sync_pkg::INDEX_BITS-1:0]       i_search_index,
	input  logic [block_sync_pkg::INDEX_BITS-1:0]       i_block_index,
	output logic                                        o_sh_ok,
	output block_sync_pkg::blk_type_e                   o_header_type,
	output logic [block_sync_pkg::PAYLOAD_BITS-1:0]     o_payload
);

	import block_sync_pkg::*;

	// two words of stream, older one in the low half
	localparam int HIST_BITS = 2 * BLOCK_BITS;

	raw_word_t              prev_word;
	logic [HIST_BITS-1:0]   history;
	raw_word_t              search_blk;
	raw_word_t              lock_blk;
	logic [1:0]             search_sh;
	logic [1:0]             lock_sh;

	// candidate block starting at bit offset k of the history
	function automatic raw_word_t pick_block
	(
		input logic [HIST_BITS-1:0]   hist,
		input logic [INDEX_BITS-1:0]  offset
	);
		raw_word_t blk;
		blk = hist[offset +: BLOCK_BITS];
		return blk;
	endfunction

	// previous word advances only on accepted input
	always_ff @(posedge i_clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			prev_word <= '0; // stream before the first word reads as zeros
		end
		else if (i_accept)
		begin
			prev_word <= i_raw;
		end
	end

	assign history = {i_raw, prev_word};

	// search offset only feeds the header check
	assign search_blk = pick_block(history, i_search_index);
	assign search_sh  = search_blk[1:0];

	// 01 and 10 are the only legal headers
	assign o_sh_ok = search_sh[0] ^ search_sh[1];

	// frozen offset gives the block handed out while locked
	assign lock_blk = pick_block(history, i_block_index);
	assign lock_sh  = lock_blk[1:0];

	always_comb
	begin
		if (lock_sh[1])
		begin
			o_header_type = BT_CTRL; // header 10
		end
		else
		begin
			o_header_type = BT_DATA; // header 01
		end
	end

	assign o_payload = lock_blk[BLOCK_BITS-1:2];

endmodule
